//--- rtl/id_pkg.sv
`default_nettype none

package id_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] alu_op_t;      // one-hot
    typedef logic [2:0]  mem_type_t;    // 000 word, 001 half, 010 byte, bit 2 unsigned
    typedef logic [2:0]  br_kind_t;

    localparam int        NREGS    = 32;
    localparam reg_addr_t LINK_REG = 5'd1;    // bl writes r1

    localparam int ALU_ADD = 0, ALU_SUB = 1, ALU_SLT = 2, ALU_SLTU = 3,
                   ALU_AND = 4, ALU_NOR = 5, ALU_OR = 6, ALU_XOR = 7,
                   ALU_SLL = 8, ALU_SRL = 9, ALU_SRA = 10, ALU_LUI = 11;

    // major opcode in inst[31:26]
    localparam logic [5:0] OPC_ALU = 6'h00, OPC_LU12I = 6'h05, OPC_PCADDU12I = 6'h07,
                           OPC_MEM = 6'h0a, OPC_JIRL = 6'h13, OPC_B = 6'h14,
                           OPC_BL = 6'h15, OPC_BEQ = 6'h16, OPC_BNE = 6'h17,
                           OPC_BLT = 6'h18, OPC_BGE = 6'h19, OPC_BLTU = 6'h1a,
                           OPC_BGEU = 6'h1b;

    // inst[25:22] under OPC_ALU
    localparam logic [3:0] OPC_GRP_REG = 4'h0, OPC_GRP_SHI = 4'h1, OPC_SLTI = 4'h8,
                           OPC_SLTUI = 4'h9, OPC_ADDI = 4'ha, OPC_ANDI = 4'hd,
                           OPC_ORI = 4'he, OPC_XORI = 4'hf;

    // inst[25:22] under OPC_MEM
    localparam logic [3:0] OPC_LD_B = 4'h0, OPC_LD_H = 4'h1, OPC_LD_W = 4'h2,
                           OPC_ST_B = 4'h4, OPC_ST_H = 4'h5, OPC_ST_W = 4'h6,
                           OPC_LD_BU = 4'h8, OPC_LD_HU = 4'h9;

    // inst[21:20]
    localparam logic [1:0] OPC_SUB_SHI = 2'h0, OPC_SUB_3R = 2'h1;

    // inst[19:15]
    localparam logic [4:0] OPC_ADD_W = 5'h00, OPC_SUB_W = 5'h02, OPC_SLT = 5'h04,
                           OPC_SLTU = 5'h05, OPC_NOR = 5'h08, OPC_AND = 5'h09,
                           OPC_OR = 5'h0a, OPC_XOR = 5'h0b, OPC_SLL_W = 5'h0e,
                           OPC_SRL_W = 5'h0f, OPC_SRA_W = 5'h10;
    localparam logic [4:0] OPC_SLLI_W = 5'h01, OPC_SRLI_W = 5'h09, OPC_SRAI_W = 5'h11;

    localparam br_kind_t BR_NONE = 3'd0, BR_EQ = 3'd1, BR_NE = 3'd2, BR_LT = 3'd3,
                         BR_GE = 3'd4, BR_LTU = 3'd5, BR_GEU = 3'd6, BR_UNCOND = 3'd7;

endpackage

`default_nettype wire

//--- rtl/fwd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fwd_if import id_pkg::*; ();

    logic      valid;      // stage will write a register
    logic      is_load;    // value arrives later
    reg_addr_t dest;
    word_t     wdata;

    modport src (
        output valid,
        output is_load,
        output dest,
        output wdata
    );

    modport sink (
        input valid,
        input is_load,
        input dest,
        input wdata
    );

endinterface

`default_nettype wire

//--- rtl/id_latch.sv
`timescale 1ns/1ps
`default_nettype none

module id_latch import id_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        in_valid,
    input  wire word_t in_pc,
    input  wire word_t in_inst,
    input  wire        ex_allowin,
    input  wire        stall,
    input  wire        br_hit,
    output logic       id_valid,
    output logic       id_allowin,
    output logic       out_valid,
    output logic       br_taken,
    output word_t      id_pc,
    output word_t      id_inst
);

    wire leaving = out_valid && ex_allowin;    // handed to EX on this edge

    assign out_valid  = id_valid && !stall;
    assign id_allowin = !id_valid || leaving;
    assign br_taken   = leaving && br_hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
        end else if (br_taken) begin
            id_valid <= 1'b0;    // squash whatever IF offers behind the branch
        end else if (id_allowin) begin
            id_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && id_allowin && !br_taken) begin
            id_pc   <= in_pc;
            id_inst <= in_inst;
        end
    end

endmodule

`default_nettype wire

//--- rtl/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import id_pkg::*; (
    input  wire word_t inst,
    output alu_op_t    alu_op,
    output word_t      imm,
    output word_t      br_offs,
    output logic       src1_is_pc,
    output logic       src2_is_imm,
    output reg_addr_t  raddr1,
    output reg_addr_t  raddr2,
    output logic       need_r1,
    output logic       need_r2,
    output reg_addr_t  dest,
    output logic       gr_we,
    output logic       mem_we,
    output logic       res_from_mem,
    output mem_type_t  mem_type,
    output br_kind_t   br_kind,
    output logic       is_jirl
);

    wire [5:0]  op_31_26 = inst[31:26];
    wire [3:0]  op_25_22 = inst[25:22];
    wire [1:0]  op_21_20 = inst[21:20];
    wire [4:0]  op_19_15 = inst[19:15];
    wire [4:0]  rd       = inst[4:0];
    wire [4:0]  rj       = inst[9:5];
    wire [4:0]  rk       = inst[14:10];
    wire [11:0] i12      = inst[21:10];
    wire [19:0] i20      = inst[24:5];
    wire [15:0] i16      = inst[25:10];
    wire [25:0] i26      = {inst[9:0], inst[25:10]};

    wire is_alu_grp = op_31_26 == OPC_ALU;
    wire is_reg_grp = is_alu_grp && op_25_22 == OPC_GRP_REG && op_21_20 == OPC_SUB_3R;
    wire is_shi_grp = is_alu_grp && op_25_22 == OPC_GRP_SHI && op_21_20 == OPC_SUB_SHI;
    wire is_mem_grp = op_31_26 == OPC_MEM;

    alu_op_t alu_3r;
    alu_op_t alu_shi;
    alu_op_t alu_imm;

    always_comb begin
        alu_3r = '0;
        if (is_reg_grp) begin
            case (op_19_15)
                OPC_ADD_W: alu_3r[ALU_ADD]  = 1'b1;
                OPC_SUB_W: alu_3r[ALU_SUB]  = 1'b1;
                OPC_SLT:   alu_3r[ALU_SLT]  = 1'b1;
                OPC_SLTU:  alu_3r[ALU_SLTU] = 1'b1;
                OPC_NOR:   alu_3r[ALU_NOR]  = 1'b1;
                OPC_AND:   alu_3r[ALU_AND]  = 1'b1;
                OPC_OR:    alu_3r[ALU_OR]   = 1'b1;
                OPC_XOR:   alu_3r[ALU_XOR]  = 1'b1;
                OPC_SLL_W: alu_3r[ALU_SLL]  = 1'b1;
                OPC_SRL_W: alu_3r[ALU_SRL]  = 1'b1;
                OPC_SRA_W: alu_3r[ALU_SRA]  = 1'b1;
                default:   alu_3r = '0;
            endcase
        end
    end

    always_comb begin
        alu_shi = '0;
        if (is_shi_grp) begin
            case (op_19_15)
                OPC_SLLI_W: alu_shi[ALU_SLL] = 1'b1;
                OPC_SRLI_W: alu_shi[ALU_SRL] = 1'b1;
                OPC_SRAI_W: alu_shi[ALU_SRA] = 1'b1;
                default:    alu_shi = '0;
            endcase
        end
    end

    always_comb begin
        alu_imm = '0;
        if (is_alu_grp) begin
            case (op_25_22)
                OPC_SLTI:  alu_imm[ALU_SLT]  = 1'b1;
                OPC_SLTUI: alu_imm[ALU_SLTU] = 1'b1;
                OPC_ADDI:  alu_imm[ALU_ADD]  = 1'b1;
                OPC_ANDI:  alu_imm[ALU_AND]  = 1'b1;
                OPC_ORI:   alu_imm[ALU_OR]   = 1'b1;
                OPC_XORI:  alu_imm[ALU_XOR]  = 1'b1;
                default:   alu_imm = '0;
            endcase
        end
    end

    always_comb begin
        case (op_31_26)
            OPC_BEQ:  br_kind = BR_EQ;
            OPC_BNE:  br_kind = BR_NE;
            OPC_BLT:  br_kind = BR_LT;
            OPC_BGE:  br_kind = BR_GE;
            OPC_BLTU: br_kind = BR_LTU;
            OPC_BGEU: br_kind = BR_GEU;
            OPC_JIRL, OPC_B, OPC_BL: br_kind = BR_UNCOND;
            default:  br_kind = BR_NONE;
        endcase
    end

    wire inst_3r    = |alu_3r;
    wire inst_shi   = |alu_shi;
    wire inst_alui  = |alu_imm;
    wire inst_logi  = alu_imm[ALU_AND] | alu_imm[ALU_OR] | alu_imm[ALU_XOR];
    wire inst_lu12i = op_31_26 == OPC_LU12I && !inst[25];
    wire inst_pcadd = op_31_26 == OPC_PCADDU12I && !inst[25];
    wire inst_ld    = is_mem_grp &&
                      op_25_22 inside {OPC_LD_B, OPC_LD_H, OPC_LD_W, OPC_LD_BU, OPC_LD_HU};
    wire inst_st    = is_mem_grp && op_25_22 inside {OPC_ST_B, OPC_ST_H, OPC_ST_W};
    wire inst_jirl  = op_31_26 == OPC_JIRL;
    wire inst_b     = op_31_26 == OPC_B;
    wire inst_bl    = op_31_26 == OPC_BL;
    wire inst_bcond = br_kind != BR_NONE && br_kind != BR_UNCOND;
    wire link       = inst_jirl | inst_bl;    // rd gets pc + 4
    wire upper20    = inst_lu12i | inst_pcadd;
    wire rd_is_src  = inst_bcond | inst_st;

    always_comb begin
        alu_op = alu_3r | alu_shi | alu_imm;
        alu_op[ALU_LUI] = inst_lu12i;
        if (alu_op == '0) begin
            alu_op[ALU_ADD] = 1'b1;    // address, link, pcaddu12i and unknown
        end
    end

    assign imm = link      ? 32'd4 :
                 upper20   ? {i20, 12'b0} :
                 inst_shi  ? {27'b0, rk} :
                 inst_logi ? {20'b0, i12} :
                             {{20{i12[11]}}, i12};
    assign br_offs = (inst_b | inst_bl) ? {{4{i26[25]}}, i26, 2'b0}
                                        : {{14{i16[15]}}, i16, 2'b0};

    assign src1_is_pc   = link | inst_pcadd;
    assign src2_is_imm  = inst_shi | inst_alui | inst_ld | inst_st | upper20 | link;
    assign raddr1       = rj;
    assign raddr2       = rd_is_src ? rd : rk;
    assign need_r1      = inst_3r | inst_shi | inst_alui | inst_ld | inst_st | inst_bcond
                        | inst_jirl;
    assign need_r2      = inst_3r | rd_is_src;
    assign dest         = inst_bl ? LINK_REG : rd;
    assign gr_we        = inst_3r | inst_shi | inst_alui | inst_ld | upper20 | link;
    assign mem_we       = inst_st;
    assign res_from_mem = inst_ld;
    assign is_jirl      = inst_jirl;

    // size in [1:0] of the sub-opcode, signedness in [3]
    assign mem_type = (inst_ld | inst_st)
                    ? {op_25_22[3], op_25_22[1:0] == 2'b00, op_25_22[1:0] == 2'b01}
                    : 3'b000;

endmodule

`default_nettype wire

//--- rtl/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile import id_pkg::*; (
    input  wire            clk,
    input  wire reg_addr_t raddr1,
    input  wire reg_addr_t raddr2,
    input  wire            we,
    input  wire reg_addr_t waddr,
    input  wire word_t     wdata,
    output word_t          rdata1,
    output word_t          rdata2
);

    word_t regs [NREGS];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 always reads zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- rtl/operand_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module operand_bypass import id_pkg::*; (
    fwd_if.sink            ex_fwd,
    fwd_if.sink            mem_fwd,
    input  wire            wb_we,
    input  wire reg_addr_t wb_dest,
    input  wire word_t     wb_wdata,
    input  wire reg_addr_t raddr1,
    input  wire reg_addr_t raddr2,
    input  wire            need_r1,
    input  wire            need_r2,
    input  wire word_t     rdata1,
    input  wire word_t     rdata2,
    output word_t          rj_value,
    output word_t          rkd_value,
    output logic           stall
);

    // only a used, nonzero source can match
    wire use1 = need_r1 && raddr1 != '0;
    wire use2 = need_r2 && raddr2 != '0;

    wire ex_hit1  = use1 && ex_fwd.valid && ex_fwd.dest == raddr1;
    wire ex_hit2  = use2 && ex_fwd.valid && ex_fwd.dest == raddr2;
    wire mem_hit1 = use1 && mem_fwd.valid && mem_fwd.dest == raddr1;
    wire mem_hit2 = use2 && mem_fwd.valid && mem_fwd.dest == raddr2;
    wire wb_hit1  = use1 && wb_we && wb_dest == raddr1;
    wire wb_hit2  = use2 && wb_we && wb_dest == raddr2;

    // youngest producer wins, so its value may still be pending
    wire wait1 = ex_hit1 ? ex_fwd.is_load : mem_hit1 && mem_fwd.is_load;
    wire wait2 = ex_hit2 ? ex_fwd.is_load : mem_hit2 && mem_fwd.is_load;

    assign rj_value  = ex_hit1  ? ex_fwd.wdata  :
                       mem_hit1 ? mem_fwd.wdata :
                       wb_hit1  ? wb_wdata      : rdata1;
    assign rkd_value = ex_hit2  ? ex_fwd.wdata  :
                       mem_hit2 ? mem_fwd.wdata :
                       wb_hit2  ? wb_wdata      : rdata2;
    assign stall     = wait1 | wait2;

endmodule

`default_nettype wire

//--- rtl/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit import id_pkg::*; (
    input  wire word_t    id_pc,
    input  wire word_t    rj_value,
    input  wire word_t    rkd_value,
    input  wire word_t    imm,
    input  wire word_t    br_offs,
    input  wire br_kind_t br_kind,
    input  wire           is_jirl,
    input  wire           src1_is_pc,
    input  wire           src2_is_imm,
    output logic          br_hit,
    output word_t         br_target,
    output word_t         alu_src1,
    output word_t         alu_src2
);

    wire eq  = rj_value == rkd_value;
    wire lt  = $signed(rj_value) < $signed(rkd_value);
    wire ltu = rj_value < rkd_value;

    always_comb begin
        case (br_kind)
            BR_EQ:     br_hit = eq;
            BR_NE:     br_hit = !eq;
            BR_LT:     br_hit = lt;
            BR_GE:     br_hit = !lt;
            BR_LTU:    br_hit = ltu;
            BR_GEU:    br_hit = !ltu;
            BR_UNCOND: br_hit = 1'b1;
            default:   br_hit = 1'b0;
        endcase
    end

    // jirl is register relative
    assign br_target = (is_jirl ? rj_value : id_pc) + br_offs;
    assign alu_src1  = src1_is_pc ? id_pc : rj_value;
    assign alu_src2  = src2_is_imm ? imm : rkd_value;

endmodule

`default_nettype wire

//--- rtl/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage import id_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            in_valid,
    input  wire word_t     in_pc,
    input  wire word_t     in_inst,
    input  wire            ex_allowin,
    input  wire            ex_fwd_valid,
    input  wire            ex_is_load,
    input  wire reg_addr_t ex_dest,
    input  wire word_t     ex_wdata,
    input  wire            mem_fwd_valid,
    input  wire reg_addr_t mem_dest,
    input  wire word_t     mem_wdata,
    input  wire            wb_we,
    input  wire reg_addr_t wb_dest,
    input  wire word_t     wb_wdata,
    output logic           id_allowin,
    output logic           out_valid,
    output alu_op_t        alu_op,
    output word_t          alu_src1,
    output word_t          alu_src2,
    output word_t          rkd_value,
    output reg_addr_t      dest,
    output logic           gr_we,
    output logic           mem_we,
    output logic           res_from_mem,
    output mem_type_t      mem_type,
    output word_t          out_pc,
    output logic           br_taken,
    output word_t          br_target
);

    word_t     id_inst;
    word_t     imm;
    word_t     br_offs;
    word_t     rdata1;
    word_t     rdata2;
    word_t     rj_value;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    br_kind_t  br_kind;
    logic      stall;
    logic      br_hit;
    logic      src1_is_pc;
    logic      src2_is_imm;
    logic      need_r1;
    logic      need_r2;
    logic      is_jirl;

    fwd_if ex_fwd ();
    fwd_if mem_fwd ();

    assign ex_fwd.valid    = ex_fwd_valid;
    assign ex_fwd.is_load  = ex_is_load;
    assign ex_fwd.dest     = ex_dest;
    assign ex_fwd.wdata    = ex_wdata;
    assign mem_fwd.valid   = mem_fwd_valid;
    assign mem_fwd.is_load = 1'b0;    // MEM result is final
    assign mem_fwd.dest    = mem_dest;
    assign mem_fwd.wdata   = mem_wdata;

    id_latch u_latch (
        .id_pc    (out_pc),
        .id_valid (),
        .*
    );

    inst_decoder u_decoder (
        .inst (id_inst),
        .*
    );

    regfile u_regfile (
        .we    (wb_we),
        .waddr (wb_dest),
        .wdata (wb_wdata),
        .*
    );

    operand_bypass u_bypass (.*);

    branch_unit u_branch (
        .id_pc (out_pc),
        .*
    );

endmodule

`default_nettype wire

//--- bench/id_checker.sv
`timescale 1ns/1ps
`default_nettype none

module id_checker import id_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            in_valid,
    input  wire word_t     in_pc,
    input  wire word_t     in_inst,
    input  wire            ex_allowin,
    input  wire            ex_fwd_valid,
    input  wire            ex_is_load,
    input  wire reg_addr_t ex_dest,
    input  wire word_t     ex_wdata,
    input  wire            mem_fwd_valid,
    input  wire reg_addr_t mem_dest,
    input  wire word_t     mem_wdata,
    input  wire            wb_we,
    input  wire reg_addr_t wb_dest,
    input  wire word_t     wb_wdata,
    input  wire            id_allowin,
    input  wire            out_valid,
    input  wire alu_op_t   alu_op,
    input  wire word_t     alu_src1,
    input  wire word_t     alu_src2,
    input  wire word_t     rkd_value,
    input  wire reg_addr_t dest,
    input  wire            gr_we,
    input  wire            mem_we,
    input  wire            res_from_mem,
    input  wire mem_type_t mem_type,
    input  wire word_t     out_pc,
    input  wire            br_taken,
    input  wire word_t     br_target,
    output int             errors,
    output int             checks
);

    localparam int K_ADD = 0, K_SUB = 1, K_ADDI = 2, K_SLLI = 3, K_AND = 4, K_OR = 5,
                   K_LU12I = 6, K_LD = 7, K_ST = 8, K_BEQ = 9, K_BNE = 10, K_BLT = 11,
                   K_BLTU = 12, K_B = 13, K_BL = 14, K_JIRL = 15;

    word_t     mirror [NREGS];
    logic      m_valid;
    word_t     m_pc;
    word_t     m_inst;

    // expected bundle of the held instruction
    alu_op_t   x_op;
    word_t     x_s1, x_s2, x_rkd, x_target;
    reg_addr_t x_dest;
    mem_type_t x_mt;
    logic      x_we, x_mwe, x_rfm, x_chk1, x_chk2, x_chkr, x_stall, x_taken;

    initial begin
        errors  = 0;
        checks  = 0;
        m_valid = 1'b0;
        m_pc    = '0;
        m_inst  = '0;
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // youngest producer first
    function automatic word_t operand(input reg_addr_t r);
        if (r == 5'd0) return '0;
        if (ex_fwd_valid && ex_dest == r) return ex_wdata;
        if (mem_fwd_valid && mem_dest == r) return mem_wdata;
        if (wb_we && wb_dest == r) return wb_wdata;
        return mirror[r];
    endfunction

    function automatic logic pending(input reg_addr_t r);
        return r != 5'd0 && ex_fwd_valid && ex_dest == r && ex_is_load;
    endfunction

    function automatic int classify(input word_t i);
        casez (i[31:15])
            17'b000000_0000_01_00000: return K_ADD;
            17'b000000_0000_01_00010: return K_SUB;
            17'b000000_0000_01_01001: return K_AND;
            17'b000000_0000_01_01010: return K_OR;
            17'b000000_0001_00_00001: return K_SLLI;
            17'b000000_1010_??_?????: return K_ADDI;
            17'b000101_0???_??_?????: return K_LU12I;
            17'b001010_0010_??_?????: return K_LD;
            17'b001010_0100_??_?????: return K_ST;
            17'b010011_????_??_?????: return K_JIRL;
            17'b010100_????_??_?????: return K_B;
            17'b010101_????_??_?????: return K_BL;
            17'b010110_????_??_?????: return K_BEQ;
            17'b010111_????_??_?????: return K_BNE;
            17'b011000_????_??_?????: return K_BLT;
            17'b011010_????_??_?????: return K_BLTU;
            default:                  return -1;
        endcase
    endfunction

    task automatic decode_held();
        int        k;
        reg_addr_t rd;
        reg_addr_t rj;
        reg_addr_t r2;
        word_t     vj;
        word_t     v2;
        word_t     si12;
        word_t     offs;
        logic      need1;
        logic      need2;
        logic      link;
        k     = classify(m_inst);
        rd    = m_inst[4:0];
        rj    = m_inst[9:5];
        need2 = k inside {K_ADD, K_SUB, K_AND, K_OR, K_ST, K_BEQ, K_BNE, K_BLT, K_BLTU};
        r2    = (k inside {K_ADD, K_SUB, K_AND, K_OR}) ? m_inst[14:10] : rd;
        need1 = !(k inside {K_LU12I, K_B, K_BL});
        link  = k inside {K_BL, K_JIRL};
        vj    = operand(rj);
        v2    = operand(r2);
        si12  = {{20{m_inst[21]}}, m_inst[21:10]};
        offs  = (k inside {K_B, K_BL}) ? {{4{m_inst[9]}}, m_inst[9:0], m_inst[25:10], 2'b00}
                                       : {{14{m_inst[25]}}, m_inst[25:10], 2'b00};
        x_op = '0;
        case (k)
            K_SUB:   x_op[ALU_SUB] = 1'b1;
            K_AND:   x_op[ALU_AND] = 1'b1;
            K_OR:    x_op[ALU_OR]  = 1'b1;
            K_SLLI:  x_op[ALU_SLL] = 1'b1;
            K_LU12I: x_op[ALU_LUI] = 1'b1;
            default: x_op[ALU_ADD] = 1'b1;    // address and link sums
        endcase
        case (k)
            K_ADDI, K_LD, K_ST: x_s2 = si12;
            K_SLLI:             x_s2 = {27'b0, m_inst[14:10]};
            K_LU12I:            x_s2 = {m_inst[24:5], 12'b0};
            K_BL, K_JIRL:       x_s2 = 32'd4;
            default:            x_s2 = v2;
        endcase
        case (k)
            K_BEQ:             x_taken = vj == v2;
            K_BNE:             x_taken = vj != v2;
            K_BLT:             x_taken = $signed(vj) < $signed(v2);
            K_BLTU:            x_taken = vj < v2;
            K_B, K_BL, K_JIRL: x_taken = 1'b1;
            default:           x_taken = 1'b0;
        endcase
        x_s1     = link ? m_pc : vj;
        x_rkd    = v2;
        x_chk1   = need1 || link;
        x_chk2   = k != K_B;    // b has no second source
        x_chkr   = need2;
        x_stall  = (need1 && pending(rj)) || (need2 && pending(r2));
        x_target = (k == K_JIRL ? vj : m_pc) + offs;
        x_dest   = k == K_BL ? 5'd1 : rd;
        x_we     = !(k inside {K_ST, K_BEQ, K_BNE, K_BLT, K_BLTU, K_B});
        x_mwe    = k == K_ST;
        x_rfm    = k == K_LD;
        x_mt     = k == K_ST ? 3'b010 : 3'b000;
    endtask

    always @(posedge clk or negedge rst_n) begin : model
        logic exp_out;
        logic leave;
        logic exp_allow;
        if (!rst_n) begin
            m_valid = 1'b0;
        end else begin
            decode_held();
            exp_out   = m_valid && !x_stall;
            leave     = exp_out && ex_allowin;
            exp_allow = !m_valid || leave;
            compare("out_valid", out_valid, exp_out);
            compare("id_allowin", id_allowin, exp_allow);
            compare("br_taken", br_taken, leave && x_taken);
            if (br_taken && !(out_valid && ex_allowin)) begin
                errors++;
                $display("br_taken raised at %0t without a transfer to EX", $time);
            end
            if (m_valid) begin
                compare("out_pc", out_pc, m_pc);
            end
            if (exp_out) begin
                compare("alu_op", alu_op, x_op);
                if (x_chk1) compare("alu_src1", alu_src1, x_s1);
                if (x_chk2) compare("alu_src2", alu_src2, x_s2);
                if (x_chkr) compare("rkd_value", rkd_value, x_rkd);
                if (x_we) compare("dest", dest, x_dest);
                compare("gr_we", gr_we, x_we);
                compare("mem_we", mem_we, x_mwe);
                compare("res_from_mem", res_from_mem, x_rfm);
                compare("mem_type", mem_type, x_mt);
            end
            if (leave && x_taken) begin
                compare("br_target", br_target, x_target);
            end

            // next state of the ID slot
            if (leave && x_taken) begin
                m_valid = 1'b0;
            end else if (exp_allow) begin
                m_valid = in_valid;
                if (in_valid) begin
                    m_pc   = in_pc;
                    m_inst = in_inst;
                end
            end
            if (wb_we && wb_dest != 5'd0) begin
                mirror[wb_dest] = wb_wdata;
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage import id_pkg::*; ();

    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam logic [31:0] LFSR_SEED = 32'd93916;

    logic      clk, rst_n, in_valid, ex_allowin;
    logic      ex_fwd_valid, ex_is_load, mem_fwd_valid, wb_we;
    word_t     in_pc, in_inst, ex_wdata, mem_wdata, wb_wdata;
    reg_addr_t ex_dest, mem_dest, wb_dest;

    logic      id_allowin, out_valid, gr_we, mem_we, res_from_mem, br_taken;
    alu_op_t   alu_op;
    word_t     alu_src1, alu_src2, rkd_value, out_pc, br_target;
    reg_addr_t dest;
    mem_type_t mem_type;

    int          errors;
    int          checks;
    int          timeouts;
    logic [31:0] lfsr;
    word_t       next_pc;    // where IF fetches next
    logic        fresh;      // last offer consumed or redirected

    id_stage dut0 (.*);
    id_checker chk0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // one LFSR step per bit
    function automatic logic [31:0] draw(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ LFSR_TAPS : lfsr >> 1;
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t random_inst();
        logic [3:0] k;
        word_t      rd;
        word_t      rj;
        word_t      rk;
        word_t      i;
        k  = 4'(draw(4));
        rd = draw(3);
        rj = draw(3) << 5;
        rk = draw(3) << 10;
        i  = draw(26);
        case (k)
            4'd1:    return 32'h0011_0000 | rk | rj | rd;                      // sub.w
            4'd2:    return 32'h0280_0000 | ((i & 32'hfff) << 10) | rj | rd;   // addi.w
            4'd3:    return 32'h0040_8000 | ((i & 32'h1f) << 10) | rj | rd;    // slli.w
            4'd4:    return 32'h0014_8000 | rk | rj | rd;                      // and
            4'd5:    return 32'h0015_0000 | rk | rj | rd;                      // or
            4'd6:    return 32'h1400_0000 | ((i & 32'hf_ffff) << 5) | rd;      // lu12i.w
            4'd7:    return 32'h2880_0000 | ((i & 32'hfff) << 10) | rj | rd;   // ld.w
            4'd8:    return 32'h2900_0000 | ((i & 32'hfff) << 10) | rj | rd;   // st.b
            4'd9:    return 32'h5800_0000 | ((i & 32'hffff) << 10) | rj | rd;  // beq
            4'd10:   return 32'h5c00_0000 | ((i & 32'hffff) << 10) | rj | rd;  // bne
            4'd11:   return 32'h6000_0000 | ((i & 32'hffff) << 10) | rj | rd;  // blt
            4'd12:   return 32'h6800_0000 | ((i & 32'hffff) << 10) | rj | rd;  // bltu
            4'd13:   return 32'h5000_0000 | ((i & 32'hffff) << 10) | (i >> 16); // b
            4'd14:   return 32'h5400_0000 | ((i & 32'hffff) << 10) | (i >> 16); // bl
            4'd15:   return 32'h4c00_0000 | ((i & 32'hffff) << 10) | rj | rd;  // jirl
            default: return 32'h0010_0000 | rk | rj | rd;                      // add.w
        endcase
    endfunction

    // IF side follows accepts and redirects
    always @(posedge clk) begin
        fresh <= br_taken || (in_valid && id_allowin);
        if (br_taken) begin
            next_pc <= br_target;
        end else if (in_valid && id_allowin) begin
            next_pc <= in_pc + 32'd4;
        end
    end

    task automatic drive_cycle();
        if (fresh) begin
            in_pc   = next_pc;
            in_inst = random_inst();
        end
        in_valid      = draw(2) != 0;
        ex_allowin    = draw(2) != 0;
        ex_fwd_valid  = draw(1) != 0;
        ex_is_load    = draw(2) == 0;
        ex_dest       = 5'(draw(3));
        ex_wdata      = draw(32);
        mem_fwd_valid = draw(1) != 0;
        mem_dest      = 5'(draw(3));
        mem_wdata     = draw(32);
        wb_we         = draw(1) != 0;
        wb_dest       = 5'(draw(3));
        wb_wdata      = draw(32);
    endtask

    initial begin
        int n;
        lfsr          = LFSR_SEED;
        timeouts      = 0;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_pc         = '0;
        in_inst       = '0;
        ex_allowin    = 1'b0;
        ex_fwd_valid  = 1'b0;
        ex_is_load    = 1'b0;
        ex_dest       = '0;
        ex_wdata      = '0;
        mem_fwd_valid = 1'b0;
        mem_dest      = '0;
        mem_wdata     = '0;
        wb_we         = 1'b0;
        wb_dest       = '0;
        wb_wdata      = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // give r1..r7 known contents
        for (int r = 1; r < 8; r++) begin
            @(negedge clk);
            wb_we    = 1'b1;
            wb_dest  = 5'(r);
            wb_wdata = draw(32);
        end
        @(negedge clk);
        wb_we   = 1'b0;
        in_pc   = 32'h1c00_0000;
        in_inst = random_inst();

        n = 0;
        while (!id_allowin && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (!id_allowin) begin
            timeouts++;
            $display("timeout: ID stage not ready for input after reset");
        end

        repeat (4000) begin
            @(negedge clk);
            drive_cycle();
        end

        // drain ID with EX open and no hazards
        @(negedge clk);
        in_valid      = 1'b0;
        ex_allowin    = 1'b1;
        ex_fwd_valid  = 1'b0;
        mem_fwd_valid = 1'b0;
        wb_we         = 1'b0;
        n = 0;
        while ((out_valid || !id_allowin) && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (out_valid || !id_allowin) begin
            timeouts++;
            $display("timeout: ID stage did not drain its last instruction");
        end
        @(negedge clk);

        $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
rtl/id_pkg.sv
rtl/fwd_if.sv
rtl/id_latch.sv
rtl/inst_decoder.sv
rtl/regfile.sv
rtl/operand_bypass.sv
rtl/branch_unit.sv
rtl/id_stage.sv
bench/id_checker.sv
bench/tb_id_stage.sv
